// ==== all.f ====
logic/conv_sum_pkg.sv
logic/stage_if.sv
logic/kernel_adder_tree.sv
logic/kernel_sum_array.sv
logic/channel_accumulator.sv
logic/scale_bias_unit.sv
logic/conv_sum_top.sv
verification/tb_conv_sum.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the conv_sum testbench with Verilator.
# Exit status is nonzero if the build fails or the testbench stops on an error.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --top-module tb_conv_sum \
    -f all.f \
    -o sim_conv_sum
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_conv_sum
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation finished cleanly"
exit 0

// ==== verification/tb_conv_sum.sv ====
// random-stimulus testbench for conv_sum_top, every output slot is checked against a datapath model
`default_nettype none

module tb_conv_sum;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TN = 4;
    localparam int LATENCY = 6;
    localparam int DRAIN_LIMIT = 50;

    // one expected output and the cycle count when it is due
    typedef struct packed {
        conv_sum_pkg::feature_t     even;
        conv_sum_pkg::feature_t     odd;
        conv_sum_pkg::channel_no_t  chan;
        int unsigned                due;
    } expected_t;

    logic                                 clk;
    logic                                 rst;
    logic                                 i_valid;
    conv_sum_pkg::kernel_mode_e           i_mode;
    conv_sum_pkg::channel_no_t            i_channel_no;
    conv_sum_pkg::kernel_taps_t [TN-1:0]  i_taps;
    conv_sum_pkg::feature_t               i_scaler;
    conv_sum_pkg::feature_t               i_bias;
    logic                                 o_valid;
    conv_sum_pkg::channel_no_t            o_channel_no;
    conv_sum_pkg::feature_t               o_result_even;
    conv_sum_pkg::feature_t               o_result_odd;

    int          seed = 32'h5953_9f06;
    int unsigned cycle = 0;
    logic        monitor_on = 1'b0;
    expected_t   expected_q[$];

    conv_sum_top #(.TN(TN)) dut (
        .clk           (clk),
        .rst           (rst),
        .i_valid       (i_valid),
        .i_mode        (i_mode),
        .i_channel_no  (i_channel_no),
        .i_taps        (i_taps),
        .i_scaler      (i_scaler),
        .i_bias        (i_bias),
        .o_valid       (o_valid),
        .o_channel_no  (o_channel_no),
        .o_result_even (o_result_even),
        .o_result_odd  (o_result_odd)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // counts rising edges to stamp items and outputs
    always @(posedge clk) cycle <= cycle + 1;

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t: o_valid got %b expected %b",
                                $time, got, exp));
    endtask

    task automatic check_feature(input conv_sum_pkg::feature_t got,
                                 input conv_sum_pkg::feature_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                $time, what, got, exp));
    endtask

    task automatic check_channel(input conv_sum_pkg::channel_no_t got,
                                 input conv_sum_pkg::channel_no_t exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t: channel got %0d expected %0d",
                                $time, got, exp));
    endtask

    function automatic logic [31:0] next_rand();
        next_rand = $random(seed);
    endfunction

    // near_ones keeps every tap within 15 of all-ones
    task automatic make_taps(input bit near_ones,
                             output conv_sum_pkg::kernel_taps_t [TN-1:0] taps);
        logic [31:0] r;
        for (int k = 0; k < TN; k++) begin
            for (int t = 0; t < conv_sum_pkg::TAPS_PER_KERNEL; t++) begin
                r = next_rand();
                if (near_ones)
                    taps[k][t] = 16'hFFFF - {12'h000, r[3:0]};
                else
                    taps[k][t] = r[15:0];
            end
        end
    endtask

    // reference model of the kernel and channel sums, the scaler product and the bias add
    task automatic model_item(input conv_sum_pkg::kernel_mode_e mode,
                              input conv_sum_pkg::kernel_taps_t [TN-1:0] taps,
                              output conv_sum_pkg::feature_t ev,
                              output conv_sum_pkg::feature_t od);
        conv_sum_pkg::feature_t even_total;
        conv_sum_pkg::feature_t odd_total;
        logic [31:0]            prod;
        even_total = '0;
        odd_total = '0;
        for (int k = 0; k < TN; k++) begin
            for (int t = 0; t < conv_sum_pkg::TAPS_PER_KERNEL; t++) begin
                if (mode == conv_sum_pkg::KN5)
                    even_total = even_total + taps[k][t];
                else if (t < conv_sum_pkg::TAPS_3X3)
                    even_total = even_total + taps[k][t];
                else if (t < 2 * conv_sum_pkg::TAPS_3X3)
                    odd_total = odd_total + taps[k][t];
            end
        end
        prod = 32'(even_total) * 32'(i_scaler);
        ev = prod[15:0] + i_bias;
        prod = 32'(odd_total) * 32'(i_scaler);
        od = prod[15:0] + i_bias;
    endtask

    task automatic send_item(input logic valid, input conv_sum_pkg::kernel_mode_e mode,
                             input conv_sum_pkg::channel_no_t chan,
                             input conv_sum_pkg::kernel_taps_t [TN-1:0] taps);
        expected_t              item;
        conv_sum_pkg::feature_t ev;
        conv_sum_pkg::feature_t od;
        @(posedge clk);
        #1;
        i_valid = valid;
        i_mode = mode;
        i_channel_no = chan;
        i_taps = taps;
        if (valid) begin
            model_item(mode, taps, ev, od);
            item.even = ev;
            item.odd = od;
            item.chan = chan;
            // accepted at the next edge and sampled LATENCY edges after that
            // so it already sits on the outputs one cycle earlier
            item.due = cycle + LATENCY;
            expected_q.push_back(item);
        end
    endtask

    task automatic send_idle();
        conv_sum_pkg::kernel_taps_t [TN-1:0] taps;
        make_taps(1'b0, taps);
        send_item(1'b0, conv_sum_pkg::KN5, '0, taps);
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (expected_q.size() != 0) begin
            if (waited >= DRAIN_LIMIT)
                abort_run("timeout: expected results never left the pipeline");
            else begin
                send_idle();
                waited++;
            end
        end
    endtask

    task automatic set_config(input conv_sum_pkg::feature_t scaler,
                              input conv_sum_pkg::feature_t bias);
        if (expected_q.size() != 0)
            abort_run("scaler and bias were about to change with items still in flight");
        else begin
            @(posedge clk);
            #1;
            i_valid = 1'b0;
            i_scaler = scaler;
            i_bias = bias;
        end
    endtask

    task automatic send_random(input bit near_ones, input bit with_gaps);
        conv_sum_pkg::kernel_taps_t [TN-1:0] taps;
        logic [31:0]                         r;
        r = next_rand();
        make_taps(near_ones, taps);
        send_item(with_gaps ? (r[7:6] != 2'b00) : 1'b1,
                  conv_sum_pkg::kernel_mode_e'(r[5]), r[4:0], taps);
    endtask

    // o_valid must be high exactly on due cycles and low otherwise
    task automatic check_outputs();
        expected_t item;
        if (expected_q.size() != 0 && expected_q[0].due < cycle)
            abort_run("an expected result was skipped by the scoreboard");
        else if (expected_q.size() != 0 && expected_q[0].due == cycle) begin
            item = expected_q.pop_front();
            check_valid(o_valid, 1'b1);
            check_channel(o_channel_no, item.chan);
            check_feature(o_result_even, item.even, "even result");
            check_feature(o_result_odd, item.odd, "odd result");
        end else begin
            check_valid(o_valid, 1'b0);
        end
    endtask

    // samples mid-cycle well clear of the edge and of the input drive
    initial begin
        forever begin
            @(posedge clk);
            #2;
            if (monitor_on)
                check_outputs();
        end
    end

    initial begin
        conv_sum_pkg::kernel_taps_t [TN-1:0] taps;
        logic [31:0]                         r;
        rst = 1'b1;
        i_valid = 1'b0;
        i_mode = conv_sum_pkg::KN5;
        i_channel_no = '0;
        i_taps = '0;
        i_scaler = '0;
        i_bias = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        monitor_on = 1'b1;

        // quiet pipeline after reset
        repeat (20) send_idle();

        // single 5x5 item
        r = next_rand();
        set_config(r[15:0], r[31:16]);
        make_taps(1'b0, taps);
        send_item(1'b1, conv_sum_pkg::KN5, 5'd3, taps);
        wait_drained();

        // single 3x3 item and then the same with taps 18..24 changed
        make_taps(1'b0, taps);
        send_item(1'b1, conv_sum_pkg::KN3, 5'd17, taps);
        for (int k = 0; k < TN; k++) begin
            for (int t = 2 * conv_sum_pkg::TAPS_3X3; t < conv_sum_pkg::TAPS_PER_KERNEL; t++) begin
                r = next_rand();
                taps[k][t] = r[15:0];
            end
        end
        send_item(1'b1, conv_sum_pkg::KN3, 5'd17, taps);
        wait_drained();

        // back-to-back mixed traffic
        repeat (300) send_random(1'b0, 1'b0);
        wait_drained();

        // random gaps in i_valid
        repeat (200) send_random(1'b0, 1'b1);
        wait_drained();

        // wraparound corners
        r = next_rand();
        set_config(16'hFFFF - {12'h000, r[3:0]}, 16'hFFFF - {12'h000, r[7:4]});
        repeat (60) send_random(1'b1, 1'b0);
        wait_drained();
        set_config(16'hFFFF, 16'hFFFF);
        repeat (60) send_random(1'b1, 1'b1);
        wait_drained();

        if (expected_q.size() != 0)
            abort_run("results were still outstanding at the end of the run");
        else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== logic/conv_sum_top.sv ====
// top level of the accumulation datapath, plain ports in and out, six cycles from taps to result
`default_nettype none

module conv_sum_top #(
    parameter int TN = 4
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  i_valid,
    input  conv_sum_pkg::kernel_mode_e            i_mode,
    input  conv_sum_pkg::channel_no_t             i_channel_no,
    input  conv_sum_pkg::kernel_taps_t [TN-1:0]   i_taps,
    input  conv_sum_pkg::feature_t                i_scaler,
    input  conv_sum_pkg::feature_t                i_bias,
    output logic                                  o_valid,
    output conv_sum_pkg::channel_no_t             o_channel_no,
    output conv_sum_pkg::feature_t                o_result_even,
    output conv_sum_pkg::feature_t                o_result_odd
);

    // per-kernel sums, then channel totals
    stage_if #(.TN(TN)) s_kernel ();
    stage_if #(.TN(TN)) s_channel ();

    // 3 cycles
    kernel_sum_array #(.TN(TN)) u_kernel_sum (
        .clk          (clk),
        .rst          (rst),
        .i_valid      (i_valid),
        .i_mode       (i_mode),
        .i_channel_no (i_channel_no),
        .i_taps       (i_taps),
        .o_stage      (s_kernel)
    );

    // 1 cycle
    channel_accumulator #(.TN(TN)) u_accumulate (
        .clk     (clk),
        .rst     (rst),
        .i_stage (s_kernel),
        .o_stage (s_channel)
    );

    // 2 cycles
    scale_bias_unit u_scale_bias (
        .clk           (clk),
        .rst           (rst),
        .i_stage       (s_channel),
        .i_scaler      (i_scaler),
        .i_bias        (i_bias),
        .o_valid       (o_valid),
        .o_channel_no  (o_channel_no),
        .o_result_even (o_result_even),
        .o_result_odd  (o_result_odd)
    );

endmodule

`default_nettype wire

// ==== logic/scale_bias_unit.sv ====
// scales both channel totals then adds the bias, two register stages at the end of the chain
`default_nettype none

module scale_bias_unit (
    input  logic                       clk,
    input  logic                       rst,
    stage_if.dst                       i_stage,
    input  conv_sum_pkg::feature_t     i_scaler,
    input  conv_sum_pkg::feature_t     i_bias,
    output logic                       o_valid,
    output conv_sum_pkg::channel_no_t  o_channel_no,
    output conv_sum_pkg::feature_t     o_result_even,
    output conv_sum_pkg::feature_t     o_result_odd
);

    logic                       valid_s1;
    conv_sum_pkg::channel_no_t  chan_s1;
    conv_sum_pkg::feature_t     scaled_even;
    conv_sum_pkg::feature_t     scaled_odd;

    // stage 1: multiply, low bits only, idle slots forced to zero
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_s1 <= 1'b0;
            chan_s1 <= '0;
            scaled_even <= '0;
            scaled_odd <= '0;
        end else begin
            valid_s1 <= i_stage.valid;
            chan_s1 <= i_stage.channel_no;
            if (i_stage.valid) begin
                scaled_even <= i_stage.even_total * i_scaler;
                scaled_odd <= i_stage.odd_total * i_scaler;
            end else begin
                scaled_even <= '0;
                scaled_odd <= '0;
            end
        end
    end

    // stage 2: bias add, wraps at FEATURE_WIDTH
    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid <= 1'b0;
            o_channel_no <= '0;
            o_result_even <= '0;
            o_result_odd <= '0;
        end else begin
            o_valid <= valid_s1;
            o_channel_no <= chan_s1;
            o_result_even <= scaled_even + i_bias;
            o_result_odd <= scaled_odd + i_bias;
        end
    end

endmodule

`default_nettype wire

// ==== logic/channel_accumulator.sv ====
// one-cycle sum of the per-kernel even and odd sums into channel totals
`default_nettype none

module channel_accumulator #(
    parameter int TN = 4
) (
    input  logic  clk,
    input  logic  rst,
    stage_if.dst  i_stage,
    stage_if.src  o_stage
);

    conv_sum_pkg::feature_t even_acc;
    conv_sum_pkg::feature_t odd_acc;

    // wrapping sums across kernels
    always_comb begin
        even_acc = '0;
        odd_acc = '0;
        for (int k = 0; k < TN; k++) begin
            even_acc = even_acc + i_stage.even_sums[k];
            odd_acc = odd_acc + i_stage.odd_sums[k];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_stage.valid <= 1'b0;
            o_stage.mode <= conv_sum_pkg::KN5;
            o_stage.channel_no <= '0;
            o_stage.even_total <= '0;
            o_stage.odd_total <= '0;
        end else begin
            o_stage.valid <= i_stage.valid;
            o_stage.mode <= i_stage.mode;
            o_stage.channel_no <= i_stage.channel_no;
            o_stage.even_total <= even_acc;
            o_stage.odd_total <= odd_acc;
        end
    end

    // per-kernel lanes end here
    assign o_stage.even_sums = '0;
    assign o_stage.odd_sums = '0;

endmodule

`default_nettype wire

// ==== logic/kernel_sum_array.sv ====
// sums TN kernels in parallel and tags each result with its delayed valid, mode and channel
`default_nettype none

module kernel_sum_array #(
    parameter int TN = 4
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  i_valid,
    input  conv_sum_pkg::kernel_mode_e            i_mode,
    input  conv_sum_pkg::channel_no_t             i_channel_no,
    input  conv_sum_pkg::kernel_taps_t [TN-1:0]   i_taps,
    stage_if.src                                  o_stage
);

    // matches the adder tree depth
    localparam int TAG_DEPTH = 3;

    logic                        valid_pipe [TAG_DEPTH];
    conv_sum_pkg::kernel_mode_e  mode_pipe [TAG_DEPTH];
    conv_sum_pkg::channel_no_t   chan_pipe [TAG_DEPTH];

    conv_sum_pkg::feature_t sum5 [TN];
    conv_sum_pkg::feature_t sum3_even [TN];
    conv_sum_pkg::feature_t sum3_odd [TN];

    // tag delay line
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int d = 0; d < TAG_DEPTH; d++) begin
                valid_pipe[d] <= 1'b0;
                mode_pipe[d] <= conv_sum_pkg::KN5;
                chan_pipe[d] <= '0;
            end
        end else begin
            valid_pipe[0] <= i_valid;
            mode_pipe[0] <= i_mode;
            chan_pipe[0] <= i_channel_no;
            for (int d = 1; d < TAG_DEPTH; d++) begin
                valid_pipe[d] <= valid_pipe[d-1];
                mode_pipe[d] <= mode_pipe[d-1];
                chan_pipe[d] <= chan_pipe[d-1];
            end
        end
    end

    for (genvar k = 0; k < TN; k++) begin : g_kernel
        kernel_adder_tree u_tree (
            .clk         (clk),
            .rst         (rst),
            .i_taps      (i_taps[k]),
            .o_sum5      (sum5[k]),
            .o_sum3_even (sum3_even[k]),
            .o_sum3_odd  (sum3_odd[k])
        );

        // 5x5 puts its sum on the even lane and nothing on the odd lane
        assign o_stage.even_sums[k] = (mode_pipe[TAG_DEPTH-1] == conv_sum_pkg::KN3)
                                    ? sum3_even[k] : sum5[k];
        assign o_stage.odd_sums[k] = (mode_pipe[TAG_DEPTH-1] == conv_sum_pkg::KN3)
                                   ? sum3_odd[k] : '0;
    end

    assign o_stage.valid = valid_pipe[TAG_DEPTH-1];
    assign o_stage.mode = mode_pipe[TAG_DEPTH-1];
    assign o_stage.channel_no = chan_pipe[TAG_DEPTH-1];

    // totals are formed in the next stage
    assign o_stage.even_total = '0;
    assign o_stage.odd_total = '0;

endmodule

`default_nettype wire

// ==== logic/kernel_adder_tree.sv ====
// three-cycle adder tree for one kernel, instantiated per kernel by kernel_sum_array
`default_nettype none

module kernel_adder_tree (
    input  logic                        clk,
    input  logic                        rst,
    input  conv_sum_pkg::kernel_taps_t  i_taps,
    output conv_sum_pkg::feature_t      o_sum5,
    output conv_sum_pkg::feature_t      o_sum3_even,
    output conv_sum_pkg::feature_t      o_sum3_odd
);

    // first tap of the odd 3x3 half and of the seven leftover taps
    localparam int ODD_BASE = conv_sum_pkg::TAPS_3X3;
    localparam int REM_BASE = 2 * conv_sum_pkg::TAPS_3X3;

    // layer 0 results: two quads plus the ninth tap per half
    conv_sum_pkg::feature_t l0_even [3];
    conv_sum_pkg::feature_t l0_odd [3];
    conv_sum_pkg::feature_t l0_rem [4];

    // layer 1 results
    conv_sum_pkg::feature_t l1_even;
    conv_sum_pkg::feature_t l1_odd;
    conv_sum_pkg::feature_t l1_rem;

    // layer 0
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int g = 0; g < 3; g++) begin
                l0_even[g] <= '0;
                l0_odd[g] <= '0;
            end
            for (int k = 0; k < 4; k++) begin
                l0_rem[k] <= '0;
            end
        end else begin
            for (int g = 0; g < 2; g++) begin
                l0_even[g] <= i_taps[4*g] + i_taps[4*g+1]
                            + i_taps[4*g+2] + i_taps[4*g+3];
                l0_odd[g] <= i_taps[ODD_BASE+4*g] + i_taps[ODD_BASE+4*g+1]
                           + i_taps[ODD_BASE+4*g+2] + i_taps[ODD_BASE+4*g+3];
            end
            // ninth tap of each half just waits one cycle
            l0_even[2] <= i_taps[ODD_BASE-1];
            l0_odd[2] <= i_taps[REM_BASE-1];
            // leftover taps 18..24 in pairs
            for (int k = 0; k < 3; k++) begin
                l0_rem[k] <= i_taps[REM_BASE+k] + i_taps[REM_BASE+4+k];
            end
            // tap 21 pairs with the zero pad
            l0_rem[3] <= i_taps[REM_BASE+3];
        end
    end

    // layer 1, one value per group
    always_ff @(posedge clk) begin
        if (rst) begin
            l1_even <= '0;
            l1_odd <= '0;
            l1_rem <= '0;
        end else begin
            l1_even <= l0_even[0] + l0_even[1] + l0_even[2];
            l1_odd <= l0_odd[0] + l0_odd[1] + l0_odd[2];
            l1_rem <= l0_rem[0] + l0_rem[1] + l0_rem[2] + l0_rem[3];
        end
    end

    // layer 2, full 5x5 sum plus the 3x3 halves held to line up with it
    always_ff @(posedge clk) begin
        if (rst) begin
            o_sum5 <= '0;
            o_sum3_even <= '0;
            o_sum3_odd <= '0;
        end else begin
            o_sum5 <= l1_even + l1_odd + l1_rem;
            o_sum3_even <= l1_even;
            o_sum3_odd <= l1_odd;
        end
    end

endmodule

`default_nettype wire

// ==== logic/stage_if.sv ====
// carries one item's tag and sums between the accumulation stages, driven through src and read through dst
`default_nettype none

interface stage_if #(
    parameter int TN = 4
);

    // item tag
    logic                        valid;
    conv_sum_pkg::kernel_mode_e  mode;
    conv_sum_pkg::channel_no_t   channel_no;

    // per-kernel sums, one slot per kernel
    conv_sum_pkg::feature_t [TN-1:0] even_sums;
    conv_sum_pkg::feature_t [TN-1:0] odd_sums;

    // sums across all kernels
    conv_sum_pkg::feature_t even_total;
    conv_sum_pkg::feature_t odd_total;

    modport src (
        output valid,
        output mode,
        output channel_no,
        output even_sums,
        output odd_sums,
        output even_total,
        output odd_total
    );

    modport dst (
        input valid,
        input mode,
        input channel_no,
        input even_sums,
        input odd_sums,
        input even_total,
        input odd_total
    );

endinterface

`default_nettype wire

// ==== logic/conv_sum_pkg.sv ====
// shared widths, kernel geometry and data types, referenced by scoped name from every RTL file
`default_nettype none

package conv_sum_pkg;

    // datapath width of taps, sums, scaler, bias and results
    localparam int FEATURE_WIDTH = 16;

    // kernel geometry
    localparam int TAPS_PER_KERNEL = 25;
    localparam int TAPS_3X3 = 9;

    // channel tag that rides along with each item
    localparam int CHANNEL_NO_WIDTH = 5;

    typedef logic [FEATURE_WIDTH-1:0] feature_t;
    typedef logic [CHANNEL_NO_WIDTH-1:0] channel_no_t;

    // KN5 gives one 25-tap sum, KN3 gives two 9-tap sums per kernel
    typedef enum logic {
        KN5 = 1'b0,
        KN3 = 1'b1
    } kernel_mode_e;

    // all taps of one kernel, tap 0 in the lowest slot
    typedef feature_t [TAPS_PER_KERNEL-1:0] kernel_taps_t;

endpackage

`default_nettype wire
